// ==== common/host_pkg.sv ====
// ==================================================
// Host domain configuration package
// Widths, window map and PMU layout shared by
// the decoder, the PMU and the top level
// ==================================================

package host_pkg;

  // Configuration bus
  typedef logic [31:0] cfg_addr_t;
  typedef logic [31:0] cfg_data_t;

  // One PMU counter or threshold
  typedef logic [31:0] pmu_cnt_t;

  // Word offset inside the PMU window
  typedef logic [3:0] pmu_offset_t;

  // Address map, each window is 4 KiB
  localparam cfg_addr_t LlcCfgBase    = 32'h0000_0000;
  localparam cfg_addr_t PmuCfgBase    = 32'h0000_1000;
  localparam cfg_addr_t CfgWindowSize = 32'h0000_1000;

  // Read pattern of the LLC window while no cache is present
  localparam cfg_data_t LlcStubRdata = 32'hDEAD_F000;

  // PMU layout
  // Event bits: 0 read hit, 1 read miss, 2 write hit, 3 write miss
  localparam int unsigned PmuNumCounters = 4;

  // Thresholds start at this word offset
  localparam int unsigned PmuThreshOffset = 4;

endpackage

// ==== pmu/pmu_counter_bank.sv ====
// ==================================================
// PMU counter bank
// One wrapping counter per event bit, loadable
// by software
// ==================================================

`timescale 1ns/1ps

module pmu_counter_bank #(
  parameter int unsigned NumCounters = host_pkg::PmuNumCounters
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [NumCounters-1:0]              evt_i,
  input  logic [NumCounters-1:0]              load_i,
  input  host_pkg::pmu_cnt_t                  load_value_i,
  output host_pkg::pmu_cnt_t [NumCounters-1:0] count_o
);

  import host_pkg::*;

  pmu_cnt_t [NumCounters-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NumCounters; i++) begin
        // Software load wins over a same cycle event
        if (load_i[i]) begin
          cnt_q[i] <= load_value_i;
        end else if (evt_i[i]) begin
          cnt_q[i] <= cnt_q[i] + pmu_cnt_t'(1);
        end
      end
    end
  end

  assign count_o = cnt_q;

endmodule

// ==== pmu/pmu_regs.sv ====
// ==================================================
// PMU register block
// Counter and threshold access, read data and
// per counter threshold interrupts
// ==================================================

`timescale 1ns/1ps

module pmu_regs #(
  parameter int unsigned NumCounters = host_pkg::PmuNumCounters
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   req_i,
  input  logic                   write_i,
  input  host_pkg::pmu_offset_t  offset_i,
  input  host_pkg::cfg_data_t    wdata_i,
  output logic                   rsp_o,
  output host_pkg::cfg_data_t    rdata_o,
  input  logic [NumCounters-1:0] evt_i,
  output logic [NumCounters-1:0] irq_o
);

  import host_pkg::*;

  pmu_cnt_t [NumCounters-1:0] count;
  pmu_cnt_t [NumCounters-1:0] thresh_q;
  logic     [NumCounters-1:0] load;
  cfg_data_t                  rdata_d;
  cfg_data_t                  rdata_q;
  logic                       rsp_q;

  pmu_counter_bank #(
    .NumCounters ( NumCounters )
  ) i_pmu_counter_bank (
    .clk_i        ( clk_i    ),
    .arst_n_i     ( arst_n_i ),
    .evt_i        ( evt_i    ),
    .load_i       ( load     ),
    .load_value_i ( wdata_i  ),
    .count_o      ( count    )
  );

  // Decode, read mux and interrupt compare
  always_comb begin
    rdata_d = '0;
    for (int i = 0; i < NumCounters; i++) begin
      load[i]  = req_i & write_i & (offset_i == pmu_offset_t'(i));
      irq_o[i] = (thresh_q[i] != '0) && (count[i] >= thresh_q[i]);
      if (offset_i == pmu_offset_t'(i)) rdata_d = count[i];
      if (offset_i == pmu_offset_t'(PmuThreshOffset + i)) rdata_d = thresh_q[i];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      thresh_q <= '0;
      rsp_q    <= 1'b0;
    end else begin
      rsp_q <= req_i;
      for (int i = 0; i < NumCounters; i++) begin
        if (req_i && write_i && offset_i == pmu_offset_t'(PmuThreshOffset + i)) begin
          thresh_q[i] <= wdata_i;
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i) rdata_q <= write_i ? '0 : rdata_d;
  end

  assign rsp_o   = rsp_q;
  assign rdata_o = rdata_q;

endmodule

// ==== design/cfg_decoder.sv ====
// ==================================================
// Host configuration decoder
// Routes requests to the LLC stub or the PMU and
// holds one response until the host takes it
// ==================================================

`timescale 1ns/1ps

module cfg_decoder (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Host request
  input  logic                  cfg_req_valid_i,
  output logic                  cfg_req_ready_o,
  input  logic                  cfg_req_write_i,
  input  host_pkg::cfg_addr_t   cfg_req_addr_i,
  input  host_pkg::cfg_data_t   cfg_req_wdata_i,
  // Host response
  output logic                  cfg_rsp_valid_o,
  input  logic                  cfg_rsp_ready_i,
  output host_pkg::cfg_data_t   cfg_rsp_rdata_o,
  output logic                  cfg_rsp_err_o,
  // PMU strobe side
  output logic                  pmu_req_o,
  output logic                  pmu_write_o,
  output host_pkg::pmu_offset_t pmu_offset_o,
  output host_pkg::cfg_data_t   pmu_wdata_o,
  input  logic                  pmu_rsp_i,
  input  host_pkg::cfg_data_t   pmu_rdata_i
);

  import host_pkg::*;

  logic      busy_q;
  logic      rsp_valid_q;
  cfg_data_t rsp_rdata_q;
  logic      rsp_err_q;
  logic      accept;
  logic      hit_llc;
  logic      hit_pmu;

  // One transaction at a time
  assign cfg_req_ready_o = ~busy_q;
  assign accept          = cfg_req_valid_i & ~busy_q;

  // Unsigned distance from the window base
  assign hit_llc = (cfg_req_addr_i - LlcCfgBase) < CfgWindowSize;
  assign hit_pmu = (cfg_req_addr_i - PmuCfgBase) < CfgWindowSize;

  // PMU strobe goes out in the accept cycle
  assign pmu_req_o    = accept & hit_pmu;
  assign pmu_write_o  = cfg_req_write_i;
  assign pmu_offset_o = cfg_req_addr_i[2 +: $bits(pmu_offset_t)];
  assign pmu_wdata_o  = cfg_req_wdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      busy_q      <= 1'b1;
      rsp_valid_q <= ~hit_pmu;
    end else if (pmu_rsp_i) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_valid_q && cfg_rsp_ready_i) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end
  end

  // Response payload, only written while no response is pending
  always_ff @(posedge clk_i) begin
    if (accept && !hit_pmu) begin
      rsp_err_q   <= ~hit_llc;
      rsp_rdata_q <= (hit_llc && !cfg_req_write_i) ? LlcStubRdata : '0;
    end else if (pmu_rsp_i) begin
      rsp_err_q   <= 1'b0;
      rsp_rdata_q <= pmu_rdata_i;
    end
  end

  assign cfg_rsp_valid_o = rsp_valid_q;
  assign cfg_rsp_rdata_o = rsp_rdata_q;
  assign cfg_rsp_err_o   = rsp_err_q;

endmodule

// ==== design/dma_evt_rx.sv ====
// ==================================================
// Cluster DMA event receiver
// Synchronizes the event level, returns the ack
// and emits one pulse per rising edge
// ==================================================

`timescale 1ns/1ps

module dma_evt_rx (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic [1:0] sync_q;
  logic       level_q;
  logic       pulse_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q  <= '0;
      level_q <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], valid_i};
      level_q <= sync_q[1];
      // Registered so the pulse trails the ack by one cycle
      pulse_q <= sync_q[1] & ~level_q;
    end
  end

  assign ack_o   = sync_q[1];
  assign valid_o = pulse_q;

endmodule

// ==== design/host_domain.sv ====
// ==================================================
// Host domain configuration plane
// Config decoder with LLC stub, PMU on the LLC
// events and the cluster DMA event receiver
// ==================================================

`timescale 1ns/1ps

module host_domain #(
  parameter int unsigned NumCounters = host_pkg::PmuNumCounters
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Host configuration port
  input  logic                   cfg_req_valid_i,
  output logic                   cfg_req_ready_o,
  input  logic                   cfg_req_write_i,
  input  host_pkg::cfg_addr_t    cfg_req_addr_i,
  input  host_pkg::cfg_data_t    cfg_req_wdata_i,
  output logic                   cfg_rsp_valid_o,
  input  logic                   cfg_rsp_ready_i,
  output host_pkg::cfg_data_t    cfg_rsp_rdata_o,
  output logic                   cfg_rsp_err_o,
  // LLC event strobes and PMU interrupts
  input  logic [NumCounters-1:0] llc_evt_i,
  output logic [NumCounters-1:0] pmu_irq_o,
  // Cluster DMA event
  input  logic                   dma_pe_evt_valid_i,
  output logic                   dma_pe_evt_o,
  output logic                   dma_pe_evt_ack_o
);

  import host_pkg::*;

  logic        pmu_req;
  logic        pmu_write;
  pmu_offset_t pmu_offset;
  cfg_data_t   pmu_wdata;
  logic        pmu_rsp;
  cfg_data_t   pmu_rdata;

  cfg_decoder i_cfg_decoder (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .cfg_req_valid_i ( cfg_req_valid_i ),
    .cfg_req_ready_o ( cfg_req_ready_o ),
    .cfg_req_write_i ( cfg_req_write_i ),
    .cfg_req_addr_i  ( cfg_req_addr_i  ),
    .cfg_req_wdata_i ( cfg_req_wdata_i ),
    .cfg_rsp_valid_o ( cfg_rsp_valid_o ),
    .cfg_rsp_ready_i ( cfg_rsp_ready_i ),
    .cfg_rsp_rdata_o ( cfg_rsp_rdata_o ),
    .cfg_rsp_err_o   ( cfg_rsp_err_o   ),
    .pmu_req_o       ( pmu_req         ),
    .pmu_write_o     ( pmu_write       ),
    .pmu_offset_o    ( pmu_offset      ),
    .pmu_wdata_o     ( pmu_wdata       ),
    .pmu_rsp_i       ( pmu_rsp         ),
    .pmu_rdata_i     ( pmu_rdata       )
  );

  pmu_regs #(
    .NumCounters ( NumCounters )
  ) i_pmu_regs (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .req_i    ( pmu_req    ),
    .write_i  ( pmu_write  ),
    .offset_i ( pmu_offset ),
    .wdata_i  ( pmu_wdata  ),
    .rsp_o    ( pmu_rsp    ),
    .rdata_o  ( pmu_rdata  ),
    .evt_i    ( llc_evt_i  ),
    .irq_o    ( pmu_irq_o  )
  );

  dma_evt_rx i_dma_evt_rx (
    .clk_i    ( clk_i              ),
    .arst_n_i ( arst_n_i           ),
    .valid_i  ( dma_pe_evt_valid_i ),
    .valid_o  ( dma_pe_evt_o       ),
    .ack_o    ( dma_pe_evt_ack_o   )
  );

endmodule

// ==== tests/host_domain_asserts.sv ====
// ==================================================
// Host domain assertions
// Response stability, single outstanding request
// and single cycle DMA event pulses
// ==================================================

`timescale 1ns/1ps

module host_domain_asserts (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                req_valid_i,
  input logic                req_ready_i,
  input logic                rsp_valid_i,
  input logic                rsp_ready_i,
  input host_pkg::cfg_data_t rsp_rdata_i,
  input logic                rsp_err_i,
  input logic                evt_pulse_i
);

  // Outstanding request seen at the port
  logic pending_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
    end else if (req_valid_i && req_ready_i) begin
      pending_q <= 1'b1;
    end else if (rsp_valid_i && rsp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  // A stalled response keeps its payload
  rsp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i) && $stable(rsp_err_i))
    else $error("Response changed while the host stalled it");

  req_blocked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pending_q |-> !req_ready_i)
    else $error("Request port ready while a response is pending");

  evt_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    evt_pulse_i |=> !evt_pulse_i)
    else $error("DMA event pulse lasted more than one cycle");

endmodule

bind host_domain host_domain_asserts i_host_domain_asserts (
  .clk_i       ( clk_i           ),
  .arst_n_i    ( arst_n_i        ),
  .req_valid_i ( cfg_req_valid_i ),
  .req_ready_i ( cfg_req_ready_o ),
  .rsp_valid_i ( cfg_rsp_valid_o ),
  .rsp_ready_i ( cfg_rsp_ready_i ),
  .rsp_rdata_i ( cfg_rsp_rdata_o ),
  .rsp_err_i   ( cfg_rsp_err_o   ),
  .evt_pulse_i ( dma_pe_evt_o    )
);

// ==== tests/host_domain_tb.sv ====
// ==================================================
// Host domain testbench
// Table driven config accesses, random LLC events,
// DMA event pulses and response back-pressure
// ==================================================

`timescale 1ns/1ps

module host_domain_tb;

  import host_pkg::*;

  localparam int NumCounters = PmuNumCounters;
  localparam int NumRows     = 16;
  localparam int EvtCycles   = 200;
  localparam int DmaEdges    = 5;

  logic                   clk_i;
  logic                   arst_n_i;
  logic                   cfg_req_valid_i;
  logic                   cfg_req_ready_o;
  logic                   cfg_req_write_i;
  cfg_addr_t              cfg_req_addr_i;
  cfg_data_t              cfg_req_wdata_i;
  logic                   cfg_rsp_valid_o;
  logic                   cfg_rsp_ready_i;
  cfg_data_t              cfg_rsp_rdata_o;
  logic                   cfg_rsp_err_o;
  logic [NumCounters-1:0] llc_evt_i;
  logic [NumCounters-1:0] pmu_irq_o;
  logic                   dma_pe_evt_valid_i;
  logic                   dma_pe_evt_o;
  logic                   dma_pe_evt_ack_o;

  // Stimulus table
  string     row_name  [NumRows];
  logic      row_write [NumRows];
  cfg_addr_t row_addr  [NumRows];
  cfg_data_t row_wdata [NumRows];
  cfg_data_t row_rdata [NumRows];
  logic      row_err   [NumRows];
  logic      row_cmp   [NumRows];

  integer      seed = 12;
  logic [31:0] rnd;
  pmu_cnt_t    model_cnt [NumCounters];
  int          pulse_cnt = 0;
  cfg_data_t   rsp_rdata;
  logic        rsp_err;

  host_domain #(.NumCounters(NumCounters)) i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Budget covers every access, the event phase and the DMA phase
  initial begin
    repeat ((NumRows + NumCounters) * 50 + EvtCycles + DmaEdges * 10 + 50) @(posedge clk_i);
    $display("Timeout: the test did not finish within its cycle budget");
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

  always @(negedge clk_i) begin
    if (dma_pe_evt_o) pulse_cnt++;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  task automatic set_row(input int idx, input string name, input logic wr, input cfg_addr_t addr,
                         input cfg_data_t wdata, input cfg_data_t rdata, input logic err,
                         input logic cmp);
    row_name[idx]  = name;
    row_write[idx] = wr;
    row_addr[idx]  = addr;
    row_wdata[idx] = wdata;
    row_rdata[idx] = rdata;
    row_err[idx]   = err;
    row_cmp[idx]   = cmp;
  endtask

  // One host access from a falling edge with a random response stall
  task automatic cfg_xfer(input string name, input logic wr, input cfg_addr_t addr,
                          input cfg_data_t wdata, output cfg_data_t rdata, output logic err);
    int hold;
    hold = $unsigned($random(seed)) % 6;
    check({name, " ready"}, 32'd1, 32'(cfg_req_ready_o));
    cfg_req_valid_i = 1'b1;
    cfg_req_write_i = wr;
    cfg_req_addr_i  = addr;
    cfg_req_wdata_i = wdata;
    @(negedge clk_i);
    // Request stays valid and must not be taken twice
    while (!cfg_rsp_valid_o) begin
      check({name, " busy"}, 32'd0, 32'(cfg_req_ready_o));
      @(negedge clk_i);
    end
    rdata = cfg_rsp_rdata_o;
    err   = cfg_rsp_err_o;
    repeat (hold) begin
      check({name, " busy"}, 32'd0, 32'(cfg_req_ready_o));
      @(negedge clk_i);
      check({name, " held valid"}, 32'd1, 32'(cfg_rsp_valid_o));
      check({name, " held rdata"}, rdata, cfg_rsp_rdata_o);
      check({name, " held err"}, 32'(err), 32'(cfg_rsp_err_o));
    end
    cfg_req_valid_i = 1'b0;
    cfg_rsp_ready_i = 1'b1;
    @(negedge clk_i);
    cfg_rsp_ready_i = 1'b0;
    check({name, " rsp done"}, 32'd0, 32'(cfg_rsp_valid_o));
  endtask

  initial begin
    arst_n_i           = 1'b0;
    cfg_req_valid_i    = 1'b0;
    cfg_req_write_i    = 1'b0;
    cfg_req_addr_i     = '0;
    cfg_req_wdata_i    = '0;
    cfg_rsp_ready_i    = 1'b0;
    llc_evt_i          = '0;
    dma_pe_evt_valid_i = 1'b0;
    for (int i = 0; i < NumCounters; i++) model_cnt[i] = '0;

    set_row(0, "llc_rd_base", 1'b0, 32'h0000_0000, '0, 32'hDEAD_F000, 1'b0, 1'b1);
    set_row(1, "llc_rd_top", 1'b0, 32'h0000_0FFC, '0, 32'hDEAD_F000, 1'b0, 1'b1);
    set_row(2, "llc_wr", 1'b1, 32'h0000_0010, 32'h1234_5678, '0, 1'b0, 1'b0);
    set_row(3, "unmapped_rd", 1'b0, 32'h0000_2000, '0, '0, 1'b1, 1'b1);
    set_row(4, "unmapped_wr", 1'b1, 32'h8000_0004, 32'hA5A5_A5A5, '0, 1'b1, 1'b1);
    set_row(5, "cnt0_wr", 1'b1, PmuCfgBase, 1000, '0, 1'b0, 1'b0);
    set_row(6, "cnt0_rd", 1'b0, PmuCfgBase, '0, 1000, 1'b0, 1'b1);
    set_row(7, "cnt1_wr", 1'b1, PmuCfgBase + 32'h04, 32'h20, '0, 1'b0, 1'b0);
    set_row(8, "cnt2_wr", 1'b1, PmuCfgBase + 32'h08, 7, '0, 1'b0, 1'b0);
    set_row(9, "cnt3_wr", 1'b1, PmuCfgBase + 32'h0C, 300, '0, 1'b0, 1'b0);
    set_row(10, "thr0_wr", 1'b1, PmuCfgBase + 32'h10, 500, '0, 1'b0, 1'b0);
    set_row(11, "thr1_wr", 1'b1, PmuCfgBase + 32'h14, 32'h21, '0, 1'b0, 1'b0);
    set_row(12, "thr2_wr", 1'b1, PmuCfgBase + 32'h18, 0, '0, 1'b0, 1'b0);
    set_row(13, "thr3_wr", 1'b1, PmuCfgBase + 32'h1C, 300, '0, 1'b0, 1'b0);
    set_row(14, "thr0_rd", 1'b0, PmuCfgBase + 32'h10, '0, 500, 1'b0, 1'b1);
    set_row(15, "pmu_gap_rd", 1'b0, PmuCfgBase + 32'h24, '0, '0, 1'b0, 1'b1);

    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check("reset rsp_valid", 32'd0, 32'(cfg_rsp_valid_o));
    check("reset req_ready", 32'd1, 32'(cfg_req_ready_o));
    check("reset irq", 32'd0, 32'(pmu_irq_o));
    check("reset dma", 32'd0, 32'({dma_pe_evt_o, dma_pe_evt_ack_o}));

    // Random LLC events where each high bit counts once
    for (int c = 0; c < EvtCycles; c++) begin
      rnd       = $random(seed);
      llc_evt_i = rnd[NumCounters-1:0];
      for (int i = 0; i < NumCounters; i++) begin
        if (llc_evt_i[i]) model_cnt[i]++;
      end
      @(negedge clk_i);
    end
    llc_evt_i = '0;
    repeat (2) @(negedge clk_i);
    for (int i = 0; i < NumCounters; i++) begin
      cfg_xfer("counter read", 1'b0, PmuCfgBase + cfg_addr_t'(4 * i), '0, rsp_rdata, rsp_err);
      check($sformatf("counter %0d", i), model_cnt[i], rsp_rdata);
      check($sformatf("counter %0d err", i), 32'd0, 32'(rsp_err));
    end

    for (int r = 0; r < NumRows; r++) begin
      cfg_xfer(row_name[r], row_write[r], row_addr[r], row_wdata[r], rsp_rdata, rsp_err);
      if (row_cmp[r]) check(row_name[r], row_rdata[r], rsp_rdata);
      check({row_name[r], " err"}, 32'(row_err[r]), 32'(rsp_err));
    end
    // Counters 0 and 3 reach their thresholds and counter 2 has none
    check("irq after thresholds", 32'b1001, 32'(pmu_irq_o));

    for (int k = 0; k < DmaEdges; k++) begin
      dma_pe_evt_valid_i = 1'b1;
      repeat (4) @(negedge clk_i);
      check("dma ack high", 32'd1, 32'(dma_pe_evt_ack_o));
      dma_pe_evt_valid_i = 1'b0;
      repeat (4) @(negedge clk_i);
      check("dma ack low", 32'd0, 32'(dma_pe_evt_ack_o));
    end
    check("dma pulses", 32'(DmaEdges), pulse_cnt);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== host_domain.f ====
common/host_pkg.sv
pmu/pmu_counter_bank.sv
pmu/pmu_regs.sv
design/cfg_decoder.sv
design/dma_evt_rx.sv
design/host_domain.sv
tests/host_domain_asserts.sv
tests/host_domain_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f host_domain.f \
		--top-module host_domain_tb -Mdir obj_dir
	out="$$(./obj_dir/Vhost_domain_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
